//--- include/proc_defines.svh
// Width and depth constants for the five-stage processor
`ifndef PROC_DEFINES_SVH
`define PROC_DEFINES_SVH

// One machine word for registers, memories and the PC
`define DATA_WIDTH 16

// Register file
`define REG_COUNT 8
`define REG_ADDR_BITS 3

// Memory sizes in words with addresses wrapping modulo depth
`define IMEM_DEPTH 64
`define DMEM_DEPTH 64

`endif

//--- rtl/isa_pkg.sv
// Instruction set types for opcodes, ALU operations and instruction fields
`default_nettype none

`include "proc_defines.svh"

package isa_pkg;

    typedef enum logic [3:0] {
        OP_HALT = 4'h0,
        OP_NOP  = 4'h1,
        OP_ADD  = 4'h2,
        OP_SUB  = 4'h3,
        OP_AND  = 4'h4,
        OP_XOR  = 4'h5,
        OP_ADDI = 4'h6,
        OP_LBI  = 4'h7,
        OP_LD   = 4'h8,
        OP_ST   = 4'h9,
        OP_BEQZ = 4'hA,
        OP_BNEZ = 4'hB     // Codes C..F trap as illegal
    } opcodeE;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_XOR,
        ALU_PASSB          // Immediate straight through for LBI
    } aluOpE;

    typedef struct packed {
        opcodeE                                       opcode;   // Bits 15..12
        logic [`REG_ADDR_BITS-1:0]                    rd;       // Bits 11..9
        logic [`REG_ADDR_BITS-1:0]                    rs;       // Bits 8..6
        logic [`REG_ADDR_BITS-1:0]                    rt;       // Bits 5..3
        logic [`DATA_WIDTH-4-3*`REG_ADDR_BITS-1:0]    lowBits;  // Rest of the immediates
    } instrFieldsT;

endpackage

`default_nettype wire

//--- rtl/pipe_pkg.sv
// Pipeline register structs passed between the processor stages
`default_nettype none

`include "proc_defines.svh"

package pipe_pkg;

    typedef struct packed {
        logic                         valid;
        logic [`DATA_WIDTH-1:0]       pc;
        logic [`DATA_WIDTH-1:0]       instr;
    } ifIdT;

    typedef struct packed {
        logic                         valid;
        logic [`DATA_WIDTH-1:0]       pc;
        logic [`REG_ADDR_BITS-1:0]    rsIdx;
        logic [`REG_ADDR_BITS-1:0]    rtIdx;     // Rd for stores
        logic [`DATA_WIDTH-1:0]       rsVal;
        logic [`DATA_WIDTH-1:0]       rtVal;
        logic [`DATA_WIDTH-1:0]       imm;       // Already sign-extended
        isa_pkg::aluOpE               aluOp;
        logic                         useImm;
        logic                         memRead;
        logic                         memWrite;
        logic                         isBranch;
        logic                         branchOnZero;
        logic                         regWrite;
        logic [`REG_ADDR_BITS-1:0]    dest;
        logic                         halt;
    } idExT;

    typedef struct packed {
        logic                         valid;
        logic [`DATA_WIDTH-1:0]       result;    // ALU result or memory address
        logic [`DATA_WIDTH-1:0]       storeData;
        logic                         memRead;
        logic                         memWrite;
        logic                         regWrite;
        logic [`REG_ADDR_BITS-1:0]    dest;
        logic                         halt;
    } exMemT;

    // MEM/WB register that also feeds the register-file write port
    typedef struct packed {
        logic                         valid;
        logic [`REG_ADDR_BITS-1:0]    dest;
        logic [`DATA_WIDTH-1:0]       value;
        logic                         regWrite;
        logic                         halt;
    } retireT;

endpackage

`default_nettype wire

//--- rtl/fetch.sv
// Fetch stage holding the PC, the loadable instruction memory and IF/ID
`timescale 1ns/10ps
`default_nettype none

`include "proc_defines.svh"

module fetch (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                progWrite,
    input  logic [$clog2(`IMEM_DEPTH)-1:0]      progAddr,
    input  logic [`DATA_WIDTH-1:0]              progData,
    input  logic                                stall,
    input  logic                                halt,
    input  logic                                redirect,
    input  logic [`DATA_WIDTH-1:0]              redirectPc,
    output pipe_pkg::ifIdT                      ifId
);

    localparam int imemAddrBits = $clog2(`IMEM_DEPTH);

    logic [`DATA_WIDTH-1:0] imem [`IMEM_DEPTH];
    logic [`DATA_WIDTH-1:0] pc;

    always_ff @(posedge clk) begin
        if (progWrite) begin
            imem[progAddr] <= progData;             // Program load port
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc         <= '0;
            ifId.valid <= 1'b0;
        end else if (redirect) begin
            pc         <= redirectPc;               // Taken branch wins
            ifId.valid <= 1'b0;
        end else if (stall) begin
            pc         <= pc;                       // Hold IF/ID for the load-use bubble
        end else if (halt) begin
            ifId.valid <= 1'b0;                     // Stop issuing behind HALT
        end else begin
            pc         <= pc + 1'b1;
            ifId.valid <= 1'b1;
            ifId.pc    <= pc;
            ifId.instr <= imem[pc[imemAddrBits-1:0]];
        end
    end

endmodule

`default_nettype wire

//--- rtl/decode.sv
// Decode stage with register file, control decode, hazard stall and ID/EX
`timescale 1ns/10ps
`default_nettype none

`include "proc_defines.svh"

module decode (
    input  logic                          clk,
    input  logic                          reset,
    input  pipe_pkg::ifIdT                ifId,
    input  logic                          flush,
    input  pipe_pkg::retireT              retire,
    input  logic                          exMemRead,
    input  logic [`REG_ADDR_BITS-1:0]     exDest,
    output pipe_pkg::idExT                idEx,
    output logic                          stall,
    output logic                          halt,
    output logic                          err
);

    logic [`DATA_WIDTH-1:0] regFile [`REG_COUNT];
    isa_pkg::instrFieldsT   fields;
    pipe_pkg::idExT         next;
    logic                   usesRs;
    logic                   usesRt;
    logic                   legal;
    logic                   isHalt;
    logic                   live;
    logic                   haltSeen;

    // Write-first read so a retiring value is seen the same cycle
    function automatic logic [`DATA_WIDTH-1:0] readReg(input logic [`REG_ADDR_BITS-1:0] idx);
        if (retire.valid && retire.regWrite && retire.dest == idx) begin
            return retire.value;
        end
        return regFile[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (retire.valid && retire.regWrite) begin
            regFile[retire.dest] <= retire.value;
        end
    end

    always_comb begin
        fields = isa_pkg::instrFieldsT'(ifId.instr);
        live   = ifId.valid && !flush && !haltSeen;   // Instruction really in ID
        usesRs = 1'b0;
        usesRt = 1'b0;
        legal  = 1'b1;
        isHalt = 1'b0;
        next   = '0;
        next.pc    = ifId.pc;
        next.rsIdx = fields.rs;
        next.rtIdx = fields.rt;
        next.dest  = fields.rd;
        next.aluOp = isa_pkg::ALU_ADD;
        next.imm   = `DATA_WIDTH'($signed({fields.rt, fields.lowBits}));
        case (fields.opcode)
            isa_pkg::OP_ADD,
            isa_pkg::OP_SUB,
            isa_pkg::OP_AND,
            isa_pkg::OP_XOR: begin
                next.aluOp    = fields.opcode == isa_pkg::OP_ADD ? isa_pkg::ALU_ADD :
                                fields.opcode == isa_pkg::OP_SUB ? isa_pkg::ALU_SUB :
                                fields.opcode == isa_pkg::OP_AND ? isa_pkg::ALU_AND :
                                isa_pkg::ALU_XOR;
                next.regWrite = 1'b1;
                usesRs        = 1'b1;
                usesRt        = 1'b1;
            end
            isa_pkg::OP_ADDI: begin
                next.useImm   = 1'b1;
                next.regWrite = 1'b1;
                usesRs        = 1'b1;
            end
            isa_pkg::OP_LBI: begin
                next.aluOp    = isa_pkg::ALU_PASSB;
                next.useImm   = 1'b1;
                next.regWrite = 1'b1;
                next.imm      = `DATA_WIDTH'($signed({fields.rs[1:0], fields.rt, fields.lowBits}));
            end
            isa_pkg::OP_LD: begin
                next.useImm   = 1'b1;
                next.memRead  = 1'b1;
                next.regWrite = 1'b1;
                usesRs        = 1'b1;
            end
            isa_pkg::OP_ST: begin
                next.rtIdx    = fields.rd;                // Store data comes from Rd
                next.useImm   = 1'b1;
                next.memWrite = 1'b1;
                usesRs        = 1'b1;
                usesRt        = 1'b1;
            end
            isa_pkg::OP_BEQZ,
            isa_pkg::OP_BNEZ: begin
                next.isBranch     = 1'b1;
                next.branchOnZero = fields.opcode == isa_pkg::OP_BEQZ;
                usesRs            = 1'b1;
            end
            isa_pkg::OP_HALT: isHalt = 1'b1;
            isa_pkg::OP_NOP:  legal  = 1'b1;
            default:          legal  = 1'b0;          // Trap
        endcase
        next.halt  = isHalt;
        next.rsVal = readReg(next.rsIdx);
        next.rtVal = readReg(next.rtIdx);
        stall = live && exMemRead &&
                ((usesRs && exDest == next.rsIdx) || (usesRt && exDest == next.rtIdx));
        halt  = haltSeen || (live && isHalt);
        next.valid = live && legal && !stall;
    end

    always_ff @(posedge clk) begin
        idEx <= next;
        if (reset) begin
            idEx.valid <= 1'b0;
            haltSeen   <= 1'b0;
            err        <= 1'b0;
        end else begin
            haltSeen <= halt;
            err      <= err || (live && !legal);      // Sticky until reset
        end
    end

endmodule

`default_nettype wire

//--- rtl/execute.sv
// Execute stage with forwarding, ALU, branch resolution and EX/MEM
`timescale 1ns/10ps
`default_nettype none

`include "proc_defines.svh"

module execute (
    input  logic                          clk,
    input  logic                          reset,
    input  pipe_pkg::idExT                idEx,
    input  pipe_pkg::exMemT               exMemFwd,
    input  pipe_pkg::retireT              retireFwd,
    output pipe_pkg::exMemT               exMem,
    output logic                          redirect,
    output logic [`DATA_WIDTH-1:0]        redirectPc,
    output logic                          exMemRead,
    output logic [`REG_ADDR_BITS-1:0]     exDest
);

    logic [`DATA_WIDTH-1:0] rsFwd;
    logic [`DATA_WIDTH-1:0] rtFwd;
    logic [`DATA_WIDTH-1:0] opB;
    logic [`DATA_WIDTH-1:0] aluOut;

    // EX/MEM result has priority over the older retiring value
    function automatic logic [`DATA_WIDTH-1:0] forward(
        input logic [`REG_ADDR_BITS-1:0] idx,
        input logic [`DATA_WIDTH-1:0]    regVal,
        input pipe_pkg::exMemT           memSlot,
        input pipe_pkg::retireT          wbSlot
    );
        if (memSlot.valid && memSlot.regWrite && !memSlot.memRead &&
            memSlot.dest == idx) begin
            return memSlot.result;
        end
        if (wbSlot.valid && wbSlot.regWrite && wbSlot.dest == idx) begin
            return wbSlot.value;
        end
        return regVal;
    endfunction

    assign rsFwd = forward(idEx.rsIdx, idEx.rsVal, exMemFwd, retireFwd);
    assign rtFwd = forward(idEx.rtIdx, idEx.rtVal, exMemFwd, retireFwd);
    assign opB   = idEx.useImm ? idEx.imm : rtFwd;

    always_comb begin
        case (idEx.aluOp)
            isa_pkg::ALU_SUB:   aluOut = rsFwd - opB;
            isa_pkg::ALU_AND:   aluOut = rsFwd & opB;
            isa_pkg::ALU_XOR:   aluOut = rsFwd ^ opB;
            isa_pkg::ALU_PASSB: aluOut = opB;
            default:            aluOut = rsFwd + opB;
        endcase
    end

    // Branch taken when Rs matches the zero test
    assign redirect   = idEx.valid && idEx.isBranch &&
                        (idEx.branchOnZero == (rsFwd == '0));
    assign redirectPc = idEx.pc + 1'b1 + idEx.imm;

    assign exMemRead = idEx.valid && idEx.memRead;   // To load-use detection
    assign exDest    = idEx.dest;

    always_ff @(posedge clk) begin
        exMem.valid     <= idEx.valid;
        exMem.result    <= aluOut;
        exMem.storeData <= rtFwd;
        exMem.memRead   <= idEx.memRead;
        exMem.memWrite  <= idEx.memWrite;
        exMem.regWrite  <= idEx.regWrite;
        exMem.dest      <= idEx.dest;
        exMem.halt      <= idEx.halt;
        if (reset) begin
            exMem.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/memory.sv
// Memory stage with data memory, load selection and the MEM/WB register
`timescale 1ns/10ps
`default_nettype none

`include "proc_defines.svh"

module memory (
    input  logic                clk,
    input  logic                reset,
    input  pipe_pkg::exMemT     exMem,
    output pipe_pkg::retireT    retire
);

    localparam int dmemAddrBits = $clog2(`DMEM_DEPTH);

    logic [`DATA_WIDTH-1:0]  dmem [`DMEM_DEPTH];
    logic [dmemAddrBits-1:0] addr;

    assign addr = exMem.result[dmemAddrBits-1:0];    // Wraps modulo depth

    always_ff @(posedge clk) begin
        if (exMem.valid && exMem.memWrite) begin
            dmem[addr] <= exMem.storeData;
        end
    end

    always_ff @(posedge clk) begin
        retire.valid    <= exMem.valid;
        retire.dest     <= exMem.dest;
        retire.value    <= exMem.memRead ? dmem[addr] : exMem.result;
        retire.regWrite <= exMem.regWrite;
        retire.halt     <= exMem.halt;
        if (reset) begin
            retire.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/proc.sv
// Five-stage in-order processor top level
`timescale 1ns/10ps
`default_nettype none

`include "proc_defines.svh"

module proc (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              progWrite,
    input  logic [$clog2(`IMEM_DEPTH)-1:0]    progAddr,
    input  logic [`DATA_WIDTH-1:0]            progData,
    output pipe_pkg::retireT                  retire,
    output logic                              halted,
    output logic                              err
);

    pipe_pkg::ifIdT              ifId;
    pipe_pkg::idExT              idEx;
    pipe_pkg::exMemT             exMem;
    logic                        stall;
    logic                        halt;
    logic                        redirect;
    logic [`DATA_WIDTH-1:0]      redirectPc;
    logic                        exMemRead;
    logic [`REG_ADDR_BITS-1:0]   exDest;

    fetch fetch_i (
        .clk        (clk),
        .reset      (reset),
        .progWrite  (progWrite),
        .progAddr   (progAddr),
        .progData   (progData),
        .stall      (stall),
        .halt       (halt),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .ifId       (ifId)
    );

    decode decode_i (
        .clk        (clk),
        .reset      (reset),
        .ifId       (ifId),
        .flush      (redirect),       // Taken branch kills the ID slot
        .retire     (retire),
        .exMemRead  (exMemRead),
        .exDest     (exDest),
        .idEx       (idEx),
        .stall      (stall),
        .halt       (halt),
        .err        (err)
    );

    execute execute_i (
        .clk        (clk),
        .reset      (reset),
        .idEx       (idEx),
        .exMemFwd   (exMem),
        .retireFwd  (retire),
        .exMem      (exMem),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .exMemRead  (exMemRead),
        .exDest     (exDest)
    );

    memory memory_i (
        .clk        (clk),
        .reset      (reset),
        .exMem      (exMem),
        .retire     (retire)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            halted <= 1'b0;
        end else if (retire.valid && retire.halt) begin
            halted <= 1'b1;                   // Stays up until reset
        end
    end

endmodule

`default_nettype wire

//--- test/clock_gen.sv
// Testbench clock and reset generator with a 5-cycle reset tail
`timescale 1ns/10ps
`default_nettype none

module clock_gen (
    input  logic hold,                          // Keeps reset up while a program loads
    output logic clk,
    output logic reset
);

    logic [2:0] holdCount = 3'd0;

    initial clk = 1'b0;
    always #50 clk = ~clk;                      // 100 ns period

    always @(posedge clk) begin
        if (hold) begin
            holdCount <= 3'd5;                  // Five more cycles after the load
        end else if (holdCount != 3'd0) begin
            holdCount <= holdCount - 1'b1;
        end
    end

    assign reset = hold || holdCount != 3'd0;

endmodule

`default_nettype wire

//--- test/proc_checker.sv
// Bound checker stepping an in-order ISA model of the loaded program
`timescale 1ns/10ps
`default_nettype none

`include "proc_defines.svh"

module proc_checker (
    input logic                              clk,
    input logic                              reset,
    input logic                              progWrite,
    input logic [$clog2(`IMEM_DEPTH)-1:0]    progAddr,
    input logic [`DATA_WIDTH-1:0]            progData,
    input pipe_pkg::retireT                  retire,
    input logic                              halted,
    input logic                              err
);

    localparam int imemBits = $clog2(`IMEM_DEPTH);
    localparam int dmemBits = $clog2(`DMEM_DEPTH);

    logic [`DATA_WIDTH-1:0]    prog [`IMEM_DEPTH];
    logic [`DATA_WIDTH-1:0]    regs [`REG_COUNT];
    logic [`DATA_WIDTH-1:0]    mem [`DMEM_DEPTH];
    logic [`DATA_WIDTH-1:0]    modelPc;
    logic [`DATA_WIDTH-1:0]    expPc;
    logic [`DATA_WIDTH-1:0]    nextPc;
    logic [`DATA_WIDTH-1:0]    instr;
    logic [`DATA_WIDTH-1:0]    imm6;
    logic [`DATA_WIDTH-1:0]    imm8;
    logic [`DATA_WIDTH-1:0]    rsVal;
    logic [`DATA_WIDTH-1:0]    addr;
    logic [`DATA_WIDTH-1:0]    expValue;
    logic [`REG_ADDR_BITS-1:0] expDest;
    isa_pkg::instrFieldsT      f;
    logic                      expRegWrite;
    logic                      expHalt;
    logic                      modelHalted = 1'b0;
    logic                      illegalLoaded = 1'b0;
    logic                      wasReset = 1'b0;
    int                        errorCount = 0;

    always_comb begin
        expPc = modelPc;
        for (int i = 0; i < `IMEM_DEPTH; i++) begin
            if (prog[expPc[imemBits-1:0]][15:12] > 4'hB) begin
                expPc = expPc + 1'b1;           // Illegal words never retire
            end
        end
        instr       = prog[expPc[imemBits-1:0]];
        f           = isa_pkg::instrFieldsT'(instr);
        imm6        = {{10{instr[5]}}, instr[5:0]};
        imm8        = {{8{instr[7]}}, instr[7:0]};
        rsVal       = regs[f.rs];
        addr        = rsVal + imm6;
        nextPc      = expPc + 1'b1;
        expDest     = f.rd;
        expValue    = '0;
        expRegWrite = 1'b0;
        expHalt     = 1'b0;
        case (f.opcode)
            isa_pkg::OP_ADD:  {expRegWrite, expValue} = {1'b1, rsVal + regs[f.rt]};
            isa_pkg::OP_SUB:  {expRegWrite, expValue} = {1'b1, rsVal - regs[f.rt]};
            isa_pkg::OP_AND:  {expRegWrite, expValue} = {1'b1, rsVal & regs[f.rt]};
            isa_pkg::OP_XOR:  {expRegWrite, expValue} = {1'b1, rsVal ^ regs[f.rt]};
            isa_pkg::OP_ADDI: {expRegWrite, expValue} = {1'b1, addr};
            isa_pkg::OP_LBI:  {expRegWrite, expValue} = {1'b1, imm8};
            isa_pkg::OP_LD:   {expRegWrite, expValue} = {1'b1, mem[addr[dmemBits-1:0]]};
            isa_pkg::OP_BEQZ: if (rsVal == '0) nextPc = expPc + 1'b1 + imm6;
            isa_pkg::OP_BNEZ: if (rsVal != '0) nextPc = expPc + 1'b1 + imm6;
            isa_pkg::OP_HALT: expHalt = 1'b1;
            default:          expHalt = 1'b0;
        endcase
    end

    always @(posedge clk) begin
        wasReset <= reset;
        if (reset && !wasReset) begin
            illegalLoaded <= 1'b0;              // New program on its way
        end
        if (progWrite) begin
            prog[progAddr] <= progData;
            if (progData[15:12] > 4'hB) begin
                illegalLoaded <= 1'b1;
            end
        end
        if (reset) begin
            modelPc     <= '0;
            modelHalted <= 1'b0;
        end else if (retire.valid) begin
            modelPc <= nextPc;
            if (expRegWrite) begin
                regs[expDest] <= expValue;
            end
            if (f.opcode == isa_pkg::OP_ST) begin
                mem[addr[dmemBits-1:0]] <= regs[f.rd];
            end
            if (expHalt) begin
                modelHalted <= 1'b1;
            end
        end
    end

    // A flushed instruction shows up as the wrong kind on the path
    retireKind: assert property (@(posedge clk) disable iff (reset)
        retire.valid |-> retire.regWrite == expRegWrite && retire.halt == expHalt)
        else begin
            errorCount++;
            $error("[ERROR] %0t retire.regWrite/halt expected %0b/%0b got %0b/%0b", $time,
                   $sampled(expRegWrite), $sampled(expHalt),
                   $sampled(retire.regWrite), $sampled(retire.halt));
        end

    retireDest: assert property (@(posedge clk) disable iff (reset)
        retire.valid && expRegWrite |-> retire.dest == expDest)
        else begin
            errorCount++;
            $error("[ERROR] %0t retire.dest expected %0d got %0d", $time,
                   $sampled(expDest), $sampled(retire.dest));
        end

    retireValue: assert property (@(posedge clk) disable iff (reset)
        retire.valid && expRegWrite |-> retire.value == expValue)
        else begin
            errorCount++;
            $error("[ERROR] %0t retire.value expected %h got %h", $time,
                   $sampled(expValue), $sampled(retire.value));
        end

    quietAfterHalt: assert property (@(posedge clk) disable iff (reset)
        halted |-> !retire.valid)
        else begin
            errorCount++;
            $error("Instruction retired after halted was raised");
        end

    haltInOrder: assert property (@(posedge clk) disable iff (reset)
        $rose(halted) |-> modelHalted)
        else begin
            errorCount++;
            $error("halted rose before the model reached HALT");
        end

    resetState: assert property (@(posedge clk)
        $fell(reset) |-> !retire.valid && !halted && !err)
        else begin
            errorCount++;
            $error("Outputs not cleared in the first cycle after reset");
        end

    errOnIllegal: assert property (@(posedge clk) disable iff (reset)
        $rose(err) |-> illegalLoaded)
        else begin
            errorCount++;
            $error("err rose without an illegal opcode in the program");
        end

endmodule

bind proc proc_checker checker_i (
    .clk       (clk),
    .reset     (reset),
    .progWrite (progWrite),
    .progAddr  (progAddr),
    .progData  (progData),
    .retire    (retire),
    .halted    (halted),
    .err       (err)
);

`default_nettype wire

//--- test/proc_tb.sv
// Testbench loading three programs into the processor and waiting for halt
`timescale 1ns/10ps
`default_nettype none

`include "proc_defines.svh"

module proc_tb;

    localparam int addrBits   = $clog2(`IMEM_DEPTH);
    localparam int cycleLimit = 600;            // 3 programs, 40 instr, 4 cycles, drain

    logic                      clk;
    logic                      reset;
    logic                      hold;
    logic                      progWrite;
    logic [addrBits-1:0]       progAddr;
    logic [`DATA_WIDTH-1:0]    progData;
    pipe_pkg::retireT          retire;
    logic                      halted;
    logic                      err;
    logic [`DATA_WIDTH-1:0]    code [$];
    int                        cycleCount = 0;
    int                        seedValue;

    clock_gen clockGen_i (
        .hold  (hold),
        .clk   (clk),
        .reset (reset)
    );

    proc dut_i (
        .clk       (clk),
        .reset     (reset),
        .progWrite (progWrite),
        .progAddr  (progAddr),
        .progData  (progData),
        .retire    (retire),
        .halted    (halted),
        .err       (err)
    );

    task automatic stopWithFailure(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped on failure");
    endtask

    function automatic logic [15:0] encodeReg(isa_pkg::opcodeE op, int rd, int rs, int rt);
        return {op, rd[2:0], rs[2:0], rt[2:0], 3'b000};
    endfunction

    function automatic logic [15:0] encodeImm(isa_pkg::opcodeE op, int rd, int rs, int imm);
        return {op, rd[2:0], rs[2:0], imm[5:0]};
    endfunction

    function automatic logic [15:0] encodeLbi(int rd, logic [7:0] imm);
        return {isa_pkg::OP_LBI, rd[2:0], 1'b0, imm};
    endfunction

    // Dependent ALU chain, then stores and loads with immediate users
    task automatic buildAluProgram();
        code = {};
        code.push_back(encodeLbi(0, 8'd5));
        code.push_back(encodeLbi(1, 8'($urandom)));
        code.push_back(encodeLbi(2, 8'($urandom)));
        code.push_back(encodeReg(isa_pkg::OP_ADD, 3, 1, 2));
        code.push_back(encodeReg(isa_pkg::OP_SUB, 4, 3, 1));
        code.push_back(encodeReg(isa_pkg::OP_AND, 5, 4, 3));
        code.push_back(encodeReg(isa_pkg::OP_XOR, 6, 5, 4));
        code.push_back(encodeImm(isa_pkg::OP_ADDI, 7, 6, -3));
        code.push_back(encodeImm(isa_pkg::OP_ST, 7, 0, 2));
        code.push_back(encodeImm(isa_pkg::OP_ST, 3, 0, -1));
        code.push_back(encodeImm(isa_pkg::OP_LD, 1, 0, 2));
        code.push_back(encodeReg(isa_pkg::OP_ADD, 2, 1, 1));   // Load-use stall
        code.push_back(encodeImm(isa_pkg::OP_LD, 4, 0, -1));
        code.push_back(encodeImm(isa_pkg::OP_ADDI, 5, 4, 7));
        code.push_back(encodeReg(isa_pkg::OP_XOR, 6, 2, 5));
        code.push_back(16'h0000);                               // HALT
    endtask

    // Taken and not-taken branches with flushed instructions behind them
    task automatic buildBranchProgram();
        code = {};
        code.push_back(encodeLbi(1, 8'd0));
        code.push_back(encodeLbi(2, 8'($urandom) | 8'h01));
        code.push_back(encodeImm(isa_pkg::OP_BEQZ, 0, 1, 2));
        code.push_back(encodeLbi(3, 8'd1));
        code.push_back(encodeLbi(4, 8'd2));
        code.push_back(encodeImm(isa_pkg::OP_BNEZ, 0, 1, 3));
        code.push_back(encodeImm(isa_pkg::OP_ADDI, 3, 2, 1));
        code.push_back(encodeImm(isa_pkg::OP_BNEZ, 0, 2, 2));
        code.push_back(encodeLbi(6, 8'hFF));
        code.push_back(encodeLbi(7, 8'hFF));
        code.push_back(encodeImm(isa_pkg::OP_ADDI, 5, 1, 0));
        code.push_back(encodeImm(isa_pkg::OP_BEQZ, 0, 5, 1));  // Operand from EX/MEM
        code.push_back(encodeLbi(5, 8'd9));
        code.push_back(encodeImm(isa_pkg::OP_ST, 2, 1, 4));
        code.push_back(encodeImm(isa_pkg::OP_LD, 6, 1, 4));
        code.push_back(encodeImm(isa_pkg::OP_BEQZ, 0, 6, 2));  // Stalls on the load
        code.push_back(encodeReg(isa_pkg::OP_ADD, 7, 6, 3));
        code.push_back(16'h0000);
    endtask

    task automatic buildIllegalProgram();
        code = {};
        code.push_back(encodeLbi(1, 8'($urandom)));
        code.push_back(16'hC000);
        code.push_back(encodeImm(isa_pkg::OP_ADDI, 2, 1, 1));
        code.push_back(16'hF123);
        code.push_back(encodeReg(isa_pkg::OP_XOR, 3, 2, 1));
        code.push_back(16'h0000);
    endtask

    task automatic runProgram(input logic expectErr);
        @(posedge clk);
        hold <= 1'b1;
        for (int i = 0; i < code.size(); i++) begin
            @(posedge clk);
            progWrite <= 1'b1;
            progAddr  <= addrBits'(i);
            progData  <= code[i];
        end
        @(posedge clk);
        progWrite <= 1'b0;
        hold      <= 1'b0;                     // Reset tail follows in clock_gen
        while (halted !== 1'b1) begin
            @(posedge clk);
        end
        if (err !== expectErr) begin
            stopWithFailure($sformatf("[ERROR] %0t err expected %0b got %0b",
                                      $time, expectErr, err));
        end
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            stopWithFailure($sformatf("Timeout: no final halt after %0d cycles", cycleCount));
        end else if (dut_i.checker_i.errorCount != 0) begin
            stopWithFailure("A checker assertion failed");
        end
    end

    initial begin
        hold      = 1'b1;
        progWrite = 1'b0;
        progAddr  = '0;
        progData  = '0;
        seedValue = $urandom(67);
        buildAluProgram();
        runProgram(1'b0);
        buildBranchProgram();
        runProgram(1'b0);
        buildIllegalProgram();
        runProgram(1'b1);
        @(posedge clk);
        if (dut_i.checker_i.errorCount == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            stopWithFailure("A checker assertion failed");
        end
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/fetch.sv
rtl/decode.sv
rtl/execute.sv
rtl/memory.sv
rtl/proc.sv
test/clock_gen.sv
test/proc_checker.sv
test/proc_tb.sv
